// File: rtl/byte_lane_ram.sv
`timescale 1ns/100ps

module byte_lane_ram #(
    parameter int unsigned ram_words = 256
) (
    input  logic                                 clk,
    input  logic [((ram_words > 1) ? $clog2(ram_words) : 1)-1:0] addr,
    input  logic [mem_pkg::lane_cnt-1:0]         lane_we,
    input  logic [mem_pkg::word_width-1:0]       wdata,
    output logic [mem_pkg::word_width-1:0]       rdata
);

    logic [mem_pkg::word_width-1:0] mem [ram_words];

    // Per-lane write, old word is read back on a write cycle
    always_ff @(posedge clk) begin
        for (int l = 0; l < mem_pkg::lane_cnt; l++) begin
            if (lane_we[l]) begin
                mem[addr][8*l +: 8] <= wdata[8*l +: 8];
            end
        end
        rdata <= mem[addr];
    end

endmodule

// File: rtl/client_arbiter.sv
`timescale 1ns/100ps

module client_arbiter #(
    parameter int client_cnt = 2
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [client_cnt-1:0]                     request,
    input  logic [client_cnt*mem_pkg::word_width-1:0] addr,
    input  logic [client_cnt-1:0]                     we,
    input  logic [2*client_cnt-1:0]                   width,
    input  logic [client_cnt*mem_pkg::word_width-1:0] wdata,
    input  logic                                      done,
    input  logic [mem_pkg::word_width-1:0]            rdata,
    output logic [client_cnt-1:0]                     ready,
    output logic                                      sel_request,
    output logic [mem_pkg::word_width-1:0]            sel_addr,
    output logic                                      sel_we,
    output logic [1:0]                                sel_width,
    output logic [mem_pkg::word_width-1:0]            sel_wdata,
    output logic [client_cnt*mem_pkg::word_width-1:0] client_rdata
);

    localparam int idx_width = (client_cnt > 1) ? $clog2(client_cnt) : 1;

    logic                          grant_valid;
    logic [idx_width-1:0]          grant_idx;   // Also the round-robin pointer after release
    logic                          done_q;
    logic                          found;
    logic [idx_width-1:0]          next_idx;
    logic [mem_pkg::word_width-1:0] held_rdata [client_cnt];

    // Search starts one past the last granted client
    always_comb begin : rr_search
        int cand;
        found = 1'b0;
        next_idx = grant_idx;
        for (int i = 1; i <= client_cnt; i++) begin
            cand = (int'(grant_idx) + i) % client_cnt;
            if (!found && request[cand]) begin
                found = 1'b1;
                next_idx = idx_width'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_idx <= idx_width'(client_cnt - 1);  // Client 0 wins first
            done_q <= 1'b0;
        end else begin
            done_q <= done;
            if (!grant_valid) begin
                if (found) begin
                    grant_valid <= 1'b1;
                    grant_idx <= next_idx;
                end
            end else if (done_q && !request[grant_idx]) begin
                grant_valid <= 1'b0;  // Handshake finished
            end
        end
    end

    // Forward path from the granted client
    assign sel_request = grant_valid && request[grant_idx];
    assign sel_addr = addr[grant_idx*mem_pkg::word_width +: mem_pkg::word_width];
    assign sel_we = we[grant_idx];
    assign sel_width = width[grant_idx*2 +: 2];
    assign sel_wdata = wdata[grant_idx*mem_pkg::word_width +: mem_pkg::word_width];

    always_ff @(posedge clk) begin
        if (done) begin
            held_rdata[grant_idx] <= rdata;
        end
    end

    // Return path, only the granted client sees ready
    always_comb begin
        for (int i = 0; i < client_cnt; i++) begin
            if (grant_valid && (int'(grant_idx) == i)) begin
                ready[i] = done;
                client_rdata[i*mem_pkg::word_width +: mem_pkg::word_width] = rdata;
            end else begin
                ready[i] = 1'b0;
                client_rdata[i*mem_pkg::word_width +: mem_pkg::word_width] = held_rdata[i];
            end
        end
    end

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

    // Memory word geometry
    localparam int word_width = 32;
    localparam int lane_cnt = word_width / 8;
    localparam int lane_sel_width = $clog2(lane_cnt);

    // Client access width codes
    localparam logic [1:0] acc_8 = 2'b00;
    localparam logic [1:0] acc_16 = 2'b01;
    localparam logic [1:0] acc_32 = 2'b10;

endpackage

// File: rtl/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem #(
    parameter int client_cnt = 2,
    parameter int unsigned ram_words = 256
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [client_cnt-1:0]                     request,
    input  logic [client_cnt*mem_pkg::word_width-1:0] addr,
    input  logic [client_cnt-1:0]                     we,
    input  logic [2*client_cnt-1:0]                   width,
    input  logic [client_cnt*mem_pkg::word_width-1:0] wdata,
    output logic [client_cnt*mem_pkg::word_width-1:0] rdata,
    output logic [client_cnt-1:0]                     ready
);

    localparam int ram_addr_width = (ram_words > 1) ? $clog2(ram_words) : 1;

    logic                           sel_request;
    logic [mem_pkg::word_width-1:0] sel_addr;
    logic                           sel_we;
    logic [1:0]                     sel_width;
    logic [mem_pkg::word_width-1:0] sel_wdata;
    logic                           done;
    logic [mem_pkg::word_width-1:0] seq_rdata;
    logic [ram_addr_width-1:0]      ram_addr;
    logic [mem_pkg::lane_cnt-1:0]   ram_lane_we;
    logic [mem_pkg::word_width-1:0] ram_wdata;
    logic [mem_pkg::word_width-1:0] ram_rdata;

    client_arbiter #(
        .client_cnt(client_cnt)
    ) arbiter_i (
        .clk(clk),
        .rst(rst),
        .request(request),
        .addr(addr),
        .we(we),
        .width(width),
        .wdata(wdata),
        .done(done),
        .rdata(seq_rdata),
        .ready(ready),
        .sel_request(sel_request),
        .sel_addr(sel_addr),
        .sel_we(sel_we),
        .sel_width(sel_width),
        .sel_wdata(sel_wdata),
        .client_rdata(rdata)
    );

    unaligned_access #(
        .ram_words(ram_words)
    ) seq_i (
        .clk(clk),
        .rst(rst),
        .request(sel_request),
        .addr(sel_addr),
        .we(sel_we),
        .width(sel_width),
        .wdata(sel_wdata),
        .ram_rdata(ram_rdata),
        .done(done),
        .rdata(seq_rdata),
        .ram_addr(ram_addr),
        .ram_lane_we(ram_lane_we),
        .ram_wdata(ram_wdata)
    );

    byte_lane_ram #(
        .ram_words(ram_words)
    ) ram_i (
        .clk(clk),
        .addr(ram_addr),
        .lane_we(ram_lane_we),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

endmodule

// File: rtl/unaligned_access.sv
`timescale 1ns/100ps

module unaligned_access #(
    parameter int unsigned ram_words = 256
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 request,
    input  logic [mem_pkg::word_width-1:0]       addr,
    input  logic                                 we,
    input  logic [1:0]                           width,
    input  logic [mem_pkg::word_width-1:0]       wdata,
    input  logic [mem_pkg::word_width-1:0]       ram_rdata,
    output logic                                 done,
    output logic [mem_pkg::word_width-1:0]       rdata,
    output logic [((ram_words > 1) ? $clog2(ram_words) : 1)-1:0] ram_addr,
    output logic [mem_pkg::lane_cnt-1:0]         ram_lane_we,
    output logic [mem_pkg::word_width-1:0]       ram_wdata
);

    localparam int ram_addr_width = (ram_words > 1) ? $clog2(ram_words) : 1;

    typedef enum logic [2:0] {
        st_idle,
        st_hi_addr,
        st_hi_data,
        st_lo_addr,
        st_lo_data,
        st_done
    } seq_state_t;

    seq_state_t state;

    logic [mem_pkg::lane_sel_width-1:0] off;
    logic [mem_pkg::lane_sel_width:0]   shift_hi;
    logic                               single_word;
    logic [mem_pkg::word_width-1:0]     word_idx;
    logic [ram_addr_width-1:0]          addr_lo;
    logic [ram_addr_width-1:0]          addr_hi;
    logic [mem_pkg::lane_cnt-1:0]       lanes;
    logic [mem_pkg::word_width-1:0]     rd_mask;
    logic [mem_pkg::word_width-1:0]     hi_rdata;

    // Lanes touched by an access at lane offset 0
    function automatic logic [mem_pkg::lane_cnt-1:0] width_lanes(input logic [1:0] w);
        case (w)
            mem_pkg::acc_8:  return 4'b0001;
            mem_pkg::acc_16: return 4'b0011;
            mem_pkg::acc_32: return 4'b1111;
            default:         return 4'b0000;
        endcase
    endfunction

    function automatic logic [mem_pkg::word_width-1:0] lane_bits(
        input logic [mem_pkg::lane_cnt-1:0] l
    );
        logic [mem_pkg::word_width-1:0] m;
        for (int i = 0; i < mem_pkg::lane_cnt; i++) begin
            m[8*i +: 8] = {8{l[i]}};
        end
        return m;
    endfunction

    assign off = addr[mem_pkg::lane_sel_width-1:0];
    assign shift_hi = (mem_pkg::lane_sel_width + 1)'(mem_pkg::lane_cnt) - off;

    assign single_word = (width == mem_pkg::acc_8) ||
                         (width == mem_pkg::acc_16 && off != 2'd3) ||
                         (width == mem_pkg::acc_32 && off == 2'd0);

    // Word addresses wrap at the RAM depth
    assign word_idx = addr >> mem_pkg::lane_sel_width;
    assign addr_lo = ram_addr_width'(word_idx % ram_words);
    assign addr_hi = ram_addr_width'((word_idx + 1) % ram_words);

    assign lanes = width_lanes(width) & {mem_pkg::lane_cnt{we}};
    assign rd_mask = lane_bits(width_lanes(width));

    assign done = (state == st_done) && request;

    always_comb begin
        ram_addr = addr_lo;
        ram_lane_we = '0;
        ram_wdata = wdata << (8*off);
        case (state)
            st_hi_addr: begin
                ram_addr = addr_hi;
                ram_lane_we = lanes >> shift_hi;
                ram_wdata = wdata >> (8*shift_hi);
            end
            st_hi_data: begin
                ram_addr = addr_hi;  // Keep address stable for the registered read
                ram_wdata = wdata >> (8*shift_hi);
            end
            st_lo_addr: begin
                ram_lane_we = lanes << off;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (request) begin
                        state <= single_word ? st_lo_addr : st_hi_addr;
                    end
                end
                st_hi_addr: state <= st_hi_data;
                st_hi_data: state <= st_lo_addr;
                st_lo_addr: state <= st_lo_data;
                st_lo_data: state <= st_done;
                st_done:    state <= request ? st_done : st_idle;  // Held until request drops
                default:    state <= st_idle;
            endcase
        end
    end

    // Read merge, high word bytes land above the low word bytes
    always_ff @(posedge clk) begin
        case (state)
            st_idle: hi_rdata <= '0;
            st_hi_data: hi_rdata <= ram_rdata << (8*shift_hi);
            st_lo_data: begin
                if (!we) begin
                    rdata <= (hi_rdata | (ram_rdata >> (8*off))) & rd_mask;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module mem_subsystem_tb -f src.f

output="$(./obj_dir/Vmem_subsystem_tb 2>&1 || true)"
echo "$output"

if grep -qx "No errors" <<< "$output"; then
    exit 0
fi
exit 1

// File: src.f
rtl/mem_pkg.sv
rtl/client_arbiter.sv
rtl/unaligned_access.sv
rtl/byte_lane_ram.sv
rtl/mem_subsystem.sv
tb/mem_subsystem_tb.sv

// File: tb/mem_subsystem_tb.sv
`timescale 1ns/100ps

module mem_subsystem_tb;

    localparam int client_cnt = 2;
    localparam int ram_words = 256;
    localparam int model_bytes = 256;  // First 64 words only
    localparam int ready_timeout = 50;
    localparam int burst_len = 4;

    logic                                      clk = 1'b0;
    logic                                      rst;
    logic [client_cnt-1:0]                     request;
    logic [client_cnt*mem_pkg::word_width-1:0] addr;
    logic [client_cnt-1:0]                     we;
    logic [2*client_cnt-1:0]                   width;
    logic [client_cnt*mem_pkg::word_width-1:0] wdata;
    logic [client_cnt*mem_pkg::word_width-1:0] rdata;
    logic [client_cnt-1:0]                     ready;

    logic [7:0]  model [model_bytes];  // Byte image of the RAM
    integer      seed = 32'hb2a72aea;
    int unsigned cycle_cnt = 0;
    logic        after_rst = 1'b1;
    int          served[$];
    int          ready_cycle [client_cnt];
    int          drop_cycle [client_cnt];

    logic [31:0] burst_addr [client_cnt][burst_len];
    logic [1:0]  burst_width [client_cnt][burst_len];
    logic        burst_we [client_cnt][burst_len];
    logic [31:0] burst_data [client_cnt][burst_len];

    mem_subsystem #(
        .client_cnt(client_cnt),
        .ram_words(ram_words)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .request(request),
        .addr(addr),
        .we(we),
        .width(width),
        .wdata(wdata),
        .rdata(rdata),
        .ready(ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    // Only one ready per cycle across all clients
    ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ready))
        else report_error("ready high for more than one client");

    always @(posedge clk) begin
        if (cycle_cnt > 0 && (rst || after_rst)) begin
            assert (ready == '0)
                else report_error("ready high during reset or right after it");
        end
        after_rst <= rst;
    end

    function automatic int width_bytes(input logic [1:0] w);
        if (w == mem_pkg::acc_8) begin
            return 1;
        end
        if (w == mem_pkg::acc_16) begin
            return 2;
        end
        return 4;
    endfunction

    function automatic logic [1:0] width_code(input int k);
        case (k)
            0:       return mem_pkg::acc_8;
            1:       return mem_pkg::acc_16;
            default: return mem_pkg::acc_32;
        endcase
    endfunction

    // Bytes from the access address upward, zero past the access size
    function automatic logic [31:0] predict_read(input logic [31:0] a, input logic [1:0] w);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < width_bytes(w); i++) begin
            v[8*i +: 8] = model[8'(a + 32'(i))];
        end
        return v;
    endfunction

    task automatic run_access(input int c, input logic [31:0] a, input logic [1:0] w,
                              input logic wr, input logic [31:0] d, input int hold);
        int          waited;
        logic [31:0] got;
        logic [31:0] expected;
        waited = 0;
        @(posedge clk);
        request[c] <= 1'b1;
        addr[c*mem_pkg::word_width +: mem_pkg::word_width] <= a;
        we[c] <= wr;
        width[c*2 +: 2] <= w;
        wdata[c*mem_pkg::word_width +: mem_pkg::word_width] <= d;
        @(posedge clk);
        while (!ready[c]) begin
            waited++;
            if (waited > ready_timeout) begin
                abort_run($sformatf("Timeout: client %0d never received ready", c));
            end
            @(posedge clk);
        end
        got = rdata[c*mem_pkg::word_width +: mem_pkg::word_width];
        ready_cycle[c] = cycle_cnt;
        served.push_back(c);
        if (wr) begin
            for (int i = 0; i < width_bytes(w); i++) begin
                model[8'(a + 32'(i))] = d[8*i +: 8];
            end
        end else begin
            expected = predict_read(a, w);
            assert (got == expected)
                else report_error($sformatf("client %0d read at %0h width %0d got %h expected %h",
                                            c, a, w, got, expected));
        end
        // Request kept high past ready
        repeat (hold) begin
            @(posedge clk);
            assert (ready[c])
                else report_error($sformatf("client %0d lost ready while holding request", c));
        end
        request[c] <= 1'b0;
        drop_cycle[c] = cycle_cnt;
    endtask

    task automatic run_burst(input int c);
        for (int j = 0; j < burst_len; j++) begin
            run_access(c, burst_addr[c][j], burst_width[c][j], burst_we[c][j],
                       burst_data[c][j], 0);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] wi;
        logic [31:0] off;
        logic [1:0]  w;
        request <= '1;  // Both clients request through reset
        addr <= '0;
        we <= '0;
        width <= '0;
        wdata <= '0;
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        request <= '0;

        // Give every modeled byte a known value
        for (int k = 0; k < 64; k++) begin
            d = $random(seed);
            run_access(k % 2, k * 4, mem_pkg::acc_32, 1'b1, d, 0);
        end

        // Aligned round trip
        for (int k = 0; k < 12; k++) begin
            w = width_code(k % 3);
            r = $random(seed);
            wi = r % 32'd64;
            r = $random(seed);
            off = r & 32'd3;
            if (w == mem_pkg::acc_16) begin
                off = off & 32'd2;
            end
            if (w == mem_pkg::acc_32) begin
                off = '0;
            end
            a = (wi << 2) + off;
            d = $random(seed);
            run_access(0, a, w, 1'b1, d, 0);
            run_access(1, a, w, 1'b0, '0, 0);
        end

        // Accesses that cross a word boundary, plus their neighbor bytes
        for (int k = 0; k < 8; k++) begin
            if (k % 4 == 0) begin
                w = mem_pkg::acc_16;
                off = 32'd3;
            end else begin
                w = mem_pkg::acc_32;
                off = k % 4;
            end
            r = $random(seed);
            wi = r % 32'd63;
            a = (wi << 2) + off;
            d = $random(seed);
            run_access(k % 2, a, w, 1'b1, d, 0);
            run_access(k % 2, a, w, 1'b0, '0, 0);
            run_access((k + 1) % 2, a - 1, mem_pkg::acc_8, 1'b0, '0, 0);
            run_access((k + 1) % 2, a + width_bytes(w), mem_pkg::acc_8, 1'b0, '0, 0);
        end

        // Read merge at unaligned word and offset 2 halfword
        for (int k = 0; k < 6; k++) begin
            r = $random(seed);
            wi = r % 32'd63;
            r = $random(seed);
            off = (r % 32'd3) + 1;
            run_access(0, (wi << 2) + off, mem_pkg::acc_32, 1'b0, '0, 0);
            run_access(1, (wi << 2) + 2, mem_pkg::acc_16, 1'b0, '0, 0);
        end

        // Both clients requesting back to back
        for (int c = 0; c < client_cnt; c++) begin
            for (int j = 0; j < burst_len; j++) begin
                r = $random(seed);
                burst_addr[c][j] = r % 32'd252;
                r = $random(seed);
                burst_width[c][j] = width_code(int'(r % 32'd3));
                r = $random(seed);
                burst_we[c][j] = r[0];
                burst_data[c][j] = $random(seed);
            end
        end
        served.delete();
        fork
            run_burst(0);
            run_burst(1);
        join
        assert (served.size() == client_cnt * burst_len)
            else report_error("not every burst access completed");
        for (int k = 1; k < served.size(); k++) begin
            assert (served[k] != served[k-1])
                else report_error("clients not served alternately");
        end

        // Client 0 holds request past ready while client 1 waits
        r = $random(seed);
        a = r % 32'd252;
        d = $random(seed);
        fork
            run_access(0, a, mem_pkg::acc_32, 1'b1, d, 3);
            begin
                repeat (2) @(posedge clk);
                run_access(1, a, mem_pkg::acc_16, 1'b0, '0, 0);
            end
        join
        assert (ready_cycle[1] > drop_cycle[0])
            else report_error("waiting client served before holder dropped request");

        $display("No errors");
        $finish;
    end

endmodule
